// File: logic/rom_loader_defines.svh
`ifndef ROM_LOADER_DEFINES_SVH
`define ROM_LOADER_DEFINES_SVH

// Host byte address width, as sent by the ioctl interface
`define IOCTL_AW 27

// SDRAM programming port
`define SDRAMW  23
`define PROG_DW 16

// Download indices
`define ROM_INDEX 8'd0
`define DIP_INDEX 8'd254

// Request buffer sizing
`define PROG_FIFO_DEPTH 8
// Two entries above this level cover strobes already in flight
`define PROG_WAIT_LEVEL 6

`endif

// File: logic/rom_loader_pkg.sv
`default_nettype none

`include "rom_loader_defines.svh"

package rom_loader_pkg;

    // One host write as presented on the ioctl side
    typedef struct packed {
        logic [7:0]           index;
        logic [`IOCTL_AW-1:0] addr;
        logic [7:0]           data;
    } host_wr_t;

    // One SDRAM programming request
    typedef struct packed {
        logic [`SDRAMW-1:0]  addr;
        logic [1:0]          ba;
        logic [`PROG_DW-1:0] data;
        // High means the byte lane is not written
        logic [1:0]          mask;
    } prog_req_t;

endpackage

`default_nettype wire

// File: logic/dwnld_packer.sv
`default_nettype none

`include "rom_loader_defines.svh"

module dwnld_packer (
    input  logic                   clk_rom,
    input  logic                   rst,
    input  logic                   hps_download,
    input  logic                   hps_wr,
    input  rom_loader_pkg::host_wr_t hps,
    output logic                   push,
    output rom_loader_pkg::prog_req_t req,
    output logic                   rom_active,
    output logic [31:0]            dipsw
);

    import rom_loader_pkg::*;

    logic      rom_hit;
    logic      dip_hit;
    prog_req_t req_next;

    // Index decode of the current strobe
    assign rom_hit = hps_wr && hps_download && (hps.index == `ROM_INDEX);
    assign dip_hit = hps_wr && (hps.index == `DIP_INDEX);

    // Byte address to 16-bit word request
    always_comb begin
        req_next.addr = hps.addr[`SDRAMW:1];
        req_next.ba   = hps.addr[`SDRAMW+2:`SDRAMW+1];
        req_next.data = {2{hps.data}};
        // Even bytes go to the low lane, odd bytes to the high lane
        req_next.mask = hps.addr[0] ? 2'b01 : 2'b10;
    end

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= rom_hit;
        end
    end

    // Mapped request for the buffer
    always_ff @(posedge clk_rom) begin
        if (rom_hit) begin
            req <= req_next;
        end
    end

    // ROM window tracking
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            rom_active <= 1'b0;
        end else if (!hps_download) begin
            rom_active <= 1'b0;
        end else if (rom_hit) begin
            rom_active <= 1'b1;
        end
    end

    // DIP bytes land in the lane picked by the low address bits
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            dipsw <= '0;
        end else if (dip_hit) begin
            case (hps.addr[1:0])
                2'd0: dipsw[7:0]   <= hps.data;
                2'd1: dipsw[15:8]  <= hps.data;
                2'd2: dipsw[23:16] <= hps.data;
                default: dipsw[31:24] <= hps.data;
            endcase
        end
    end

    // Back-to-back pushes need back-to-back host strobes
    push_follows_strobe: assert property (
        @(posedge clk_rom) disable iff (rst)
        push && $past(push) |-> $past(hps_wr) && $past(hps_wr, 2)
    ) else $error("push repeated without a matching host strobe");

endmodule

`default_nettype wire

// File: logic/prog_fifo.sv
`default_nettype none

`include "rom_loader_defines.svh"

module prog_fifo #(
    parameter int DEPTH = `PROG_FIFO_DEPTH
) (
    input  logic                      clk_rom,
    input  logic                      rst,
    input  logic                      push,
    input  rom_loader_pkg::prog_req_t din,
    input  logic                      pop,
    output rom_loader_pkg::prog_req_t head,
    output logic                      empty,
    output logic                      hps_wait
);

    import rom_loader_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    // Keep some headroom when the buffer is built smaller than the default
    localparam int WAIT_LEVEL = (`PROG_WAIT_LEVEL < DEPTH) ? `PROG_WAIT_LEVEL : DEPTH - 2;

    prog_req_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk_rom) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            count    <= '0;
            hps_wait <= 1'b0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One cycle behind the count
            hps_wait <= (count >= CNT_W'(WAIT_LEVEL));
        end
    end

    no_push_when_full: assert property (
        @(posedge clk_rom) disable iff (rst) push |-> !full
    ) else $error("push into a full request buffer");

    no_pop_when_empty: assert property (
        @(posedge clk_rom) disable iff (rst) pop |-> !empty
    ) else $error("pop from an empty request buffer");

endmodule

`default_nettype wire

// File: logic/prog_writer.sv
`default_nettype none

`include "rom_loader_defines.svh"

module prog_writer (
    input  logic                      clk_rom,
    input  logic                      rst,
    input  logic                      empty,
    input  rom_loader_pkg::prog_req_t head,
    input  logic                      rom_active,
    output logic                      pop,
    output logic                      prog_we,
    output logic [`SDRAMW-1:0]        prog_addr,
    output logic [1:0]                prog_ba,
    output logic [`PROG_DW-1:0]       prog_data,
    output logic [1:0]                prog_mask,
    input  logic                      prog_rdy,
    output logic                      downloading
);

    import rom_loader_pkg::*;

    // Low means idle, high means a request is being written
    logic      writing;
    prog_req_t cur;

    // Idle writer takes the head as soon as there is one
    assign pop = !writing && !empty;

    assign prog_we   = writing;
    assign prog_addr = cur.addr;
    assign prog_ba   = cur.ba;
    assign prog_data = cur.data;
    assign prog_mask = cur.mask;

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            writing <= 1'b0;
        end else if (!writing) begin
            writing <= !empty;
        end else if (prog_rdy) begin
            // Back to idle so the next pop can follow right away
            writing <= 1'b0;
        end
    end

    // Request held here until the SDRAM acknowledges it
    always_ff @(posedge clk_rom) begin
        if (pop) begin
            cur <= head;
        end
    end

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            downloading <= 1'b0;
        end else begin
            downloading <= rom_active || !empty || writing;
        end
    end

    // SDRAM may sample the fields on any cycle until it answers
    prog_fields_stable: assert property (
        @(posedge clk_rom) disable iff (rst)
        prog_we && !prog_rdy |=> prog_we && $stable({prog_addr, prog_ba, prog_data, prog_mask})
    ) else $error("prog request changed before prog_rdy");

endmodule

`default_nettype wire

// File: logic/rom_loader_top.sv
`default_nettype none

`include "rom_loader_defines.svh"

module rom_loader_top (
    input  logic                      clk_rom,
    input  logic                      rst,
    // Host download stream
    input  logic                      hps_download,
    input  logic                      hps_wr,
    input  rom_loader_pkg::host_wr_t  hps,
    output logic                      hps_wait,
    // SDRAM programming port
    output logic                      prog_we,
    output logic [`SDRAMW-1:0]        prog_addr,
    output logic [1:0]                prog_ba,
    output logic [`PROG_DW-1:0]       prog_data,
    output logic [1:0]                prog_mask,
    input  logic                      prog_rdy,
    // Status
    output logic                      downloading,
    output logic [31:0]               dipsw
);

    import rom_loader_pkg::*;

    logic      push;
    logic      pop;
    logic      empty;
    logic      rom_active;
    prog_req_t req;
    prog_req_t head;

    dwnld_packer u_packer (
        .clk_rom      ( clk_rom      ),
        .rst          ( rst          ),
        .hps_download ( hps_download ),
        .hps_wr       ( hps_wr       ),
        .hps          ( hps          ),
        .push         ( push         ),
        .req          ( req          ),
        .rom_active   ( rom_active   ),
        .dipsw        ( dipsw        )
    );

    prog_fifo #(
        .DEPTH ( `PROG_FIFO_DEPTH )
    ) u_fifo (
        .clk_rom  ( clk_rom  ),
        .rst      ( rst      ),
        .push     ( push     ),
        .din      ( req      ),
        .pop      ( pop      ),
        .head     ( head     ),
        .empty    ( empty    ),
        .hps_wait ( hps_wait )
    );

    prog_writer u_writer (
        .clk_rom     ( clk_rom     ),
        .rst         ( rst         ),
        .empty       ( empty       ),
        .head        ( head        ),
        .rom_active  ( rom_active  ),
        .pop         ( pop         ),
        .prog_we     ( prog_we     ),
        .prog_addr   ( prog_addr   ),
        .prog_ba     ( prog_ba     ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_rdy    ( prog_rdy    ),
        .downloading ( downloading )
    );

endmodule

`default_nettype wire

// File: dv/prog_checker.sv
`default_nettype none

`include "rom_loader_defines.svh"

module prog_checker (
    input  logic                      clk_rom,
    input  logic                      rst,
    input  logic                      exp_valid,
    input  rom_loader_pkg::prog_req_t exp_req,
    input  logic                      dip_valid,
    input  logic [31:0]               dip_expected,
    input  logic                      run_done,
    input  logic                      prog_we,
    input  logic [`SDRAMW-1:0]        prog_addr,
    input  logic [1:0]                prog_ba,
    input  logic [`PROG_DW-1:0]       prog_data,
    input  logic [1:0]                prog_mask,
    input  logic                      prog_rdy,
    input  logic                      hps_wait,
    input  logic                      downloading,
    input  logic [31:0]               dipsw,
    output int                        mismatch_count,
    output int                        other_count,
    output int                        pending
);
    timeunit 1ns;
    timeprecision 1ps;

    import rom_loader_pkg::*;

    prog_req_t expected [$];
    prog_req_t seen;
    prog_req_t held;
    logic      held_valid = 1'b0;
    logic      was_rst = 1'b0;
    logic      wait_seen = 1'b0;
    int        busy_age = 0;
    int        mismatches = 0;
    int        others = 0;
    int        queued = 0;

    assign mismatch_count = mismatches;
    assign other_count    = others;
    assign pending        = queued;

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] want);
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        mismatches++;
    endtask

    task automatic note_failure(string what);
        $display("ERROR: %s at %0t", what, $time);
        others++;
    endtask

    // Oldest outstanding ROM byte against the write the SDRAM just took
    task automatic check_write();
        prog_req_t want;
        if (expected.size() == 0) begin
            note_failure("SDRAM write seen with no ROM byte outstanding");
        end else begin
            want = expected.pop_front();
            if (seen.addr !== want.addr) report_mismatch("prog_addr", seen.addr, want.addr);
            if (seen.ba !== want.ba) report_mismatch("prog_ba", seen.ba, want.ba);
            if (seen.data !== want.data) report_mismatch("prog_data", seen.data, want.data);
            if (seen.mask !== want.mask) report_mismatch("prog_mask", seen.mask, want.mask);
        end
    endtask

    always @(posedge clk_rom) begin
        seen = '{addr: prog_addr, ba: prog_ba, data: prog_data, mask: prog_mask};
        if (was_rst && (prog_we !== 1'b0 || hps_wait !== 1'b0 || downloading !== 1'b0
                        || dipsw !== 32'd0)) begin
            note_failure("outputs not cleared by reset");
        end
        was_rst = rst;
        if (!rst) begin
            if (exp_valid) expected.push_back(exp_req);
            if (hps_wait) wait_seen = 1'b1;
            // Held from the rise of prog_we through prog_rdy
            if (held_valid && prog_we !== 1'b1) begin
                note_failure("prog_we dropped before prog_rdy");
            end else if (held_valid && seen !== held) begin
                report_mismatch("prog fields", seen, held);
            end
            held = seen;
            held_valid = prog_we && !prog_rdy;
            if (prog_we && prog_rdy) check_write();
            if (dip_valid && dipsw !== dip_expected) report_mismatch("dipsw", dipsw, dip_expected);
            busy_age = (expected.size() > 0) ? busy_age + 1 : 0;
            // Registered status lags a fresh ROM byte by two cycles
            if (busy_age > 2 && !downloading) begin
                note_failure("downloading low while ROM writes are outstanding");
            end
            if (run_done) begin
                if (expected.size() != 0) begin
                    note_failure($sformatf("%0d ROM writes never reached the SDRAM",
                                           expected.size()));
                end
                if (!wait_seen) note_failure("hps_wait never rose during the burst");
                if (downloading) note_failure("downloading still high after the last write");
            end
            queued = expected.size();
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_rom_loader.sv
`default_nettype none

`include "rom_loader_defines.svh"

module tb_rom_loader;
    timeunit 1ns;
    timeprecision 1ps;

    import rom_loader_pkg::*;

    logic                clk_rom;
    logic                rst;
    logic                hps_download;
    logic                hps_wr;
    host_wr_t            hps;
    logic                hps_wait;
    logic                prog_we;
    logic [`SDRAMW-1:0]  prog_addr;
    logic [1:0]          prog_ba;
    logic [`PROG_DW-1:0] prog_data;
    logic [1:0]          prog_mask;
    logic                prog_rdy;
    logic                downloading;
    logic [31:0]         dipsw;

    // Expectations handed to the checker
    logic                exp_valid;
    prog_req_t           exp_req;
    logic                dip_valid;
    logic [31:0]         dip_expected;
    logic                run_done;
    int                  mismatch_count;
    int                  other_count;
    int                  pending;

    string               lines [$];
    int                  bad_lines;
    int                  cycle_count;
    int                  cycle_limit;
    logic [15:0]         lfsr;
    int                  idle_left;

    always #5 clk_rom = ~clk_rom;

    rom_loader_top DUT (.*);

    prog_checker chk (.*);

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr[0];
        lfsr = (lfsr >> 1) ^ (out ? 16'hB400 : 16'h0000);
        return out;
    endfunction

    function automatic logic [2:0] ready_delay();
        logic [2:0] d;
        for (int i = 0; i < 3; i++) d[i] = lfsr_bit();
        return d;
    endfunction

    // ROM byte to 16-bit word request
    function automatic prog_req_t rom_request(logic [`IOCTL_AW-1:0] byte_addr, logic [7:0] value);
        prog_req_t r;
        r.addr = byte_addr[23:1];
        r.ba   = byte_addr[25:24];
        r.data = {value, value};
        r.mask = byte_addr[0] ? 2'b01 : 2'b10;
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk_rom);
        #1;
        hps_wr = 1'b0;
        exp_valid = 1'b0;
        dip_valid = 1'b0;
        run_done = 1'b0;
    endtask

    task automatic host_write(logic [7:0] idx, logic [`IOCTL_AW-1:0] byte_addr, logic [7:0] value);
        next_cycle();
        // Hold off while the buffer is nearly full
        while (hps_wait) next_cycle();
        hps.index = idx;
        hps.addr = byte_addr;
        hps.data = value;
        hps_wr = 1'b1;
        if (idx == `ROM_INDEX && hps_download) begin
            exp_req = rom_request(byte_addr, value);
            exp_valid = 1'b1;
        end
    endtask

    task automatic run_line(string line);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        string       args;
        args = line.substr(1, line.len() - 1);
        case (line.getc(0))
            "D": begin
                void'($sscanf(args, "%h", a));
                next_cycle();
                hps_download = a[0];
            end
            "W": begin
                void'($sscanf(args, "%h %h %h", a, b, c));
                host_write(a[7:0], b[`IOCTL_AW-1:0], c[7:0]);
            end
            "E": begin
                void'($sscanf(args, "%h", a));
                next_cycle();
                dip_expected = a;
                dip_valid = 1'b1;
            end
            default: begin
                $display("Stimulus line not understood: %s", line);
                bad_lines++;
            end
        endcase
    endtask

    // SDRAM model answering with a one-cycle prog_rdy after 0 to 7 idle cycles
    always @(posedge clk_rom) begin
        #1;
        if (rst || prog_rdy) begin
            prog_rdy = 1'b0;
            idle_left = -1;
        end else if (prog_we) begin
            if (idle_left < 0) idle_left = ready_delay();
            if (idle_left == 0) prog_rdy = 1'b1;
            else idle_left--;
        end
    end

    always @(posedge clk_rom) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int    fd;
        string line;
        clk_rom = 1'b0;
        rst = 1'b1;
        hps_download = 1'b0;
        hps_wr = 1'b0;
        hps = '0;
        prog_rdy = 1'b0;
        exp_valid = 1'b0;
        exp_req = '0;
        dip_valid = 1'b0;
        dip_expected = '0;
        run_done = 1'b0;
        bad_lines = 0;
        cycle_count = 0;
        lfsr = 16'd61706;
        idle_left = -1;
        fd = $fopen("dv/rom_loader_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = 20 * lines.size() + 200;
        if (lines.size() == 0) begin
            $display("No stimulus lines could be read from dv/rom_loader_stimulus.txt");
            $display("Test failures found");
            $finish;
        end else begin
            repeat (5) @(posedge clk_rom);
            #1;
            rst = 1'b0;
            foreach (lines[i]) run_line(lines[i]);
            next_cycle();
            // Wait until every ROM byte has reached the SDRAM
            while (pending != 0) next_cycle();
            repeat (3) next_cycle();
            run_done = 1'b1;
            next_cycle();
            next_cycle();
            $display("Errors: %0d mismatches, %0d other failures, %0d bad stimulus lines",
                     mismatch_count, other_count, bad_lines);
            if (mismatch_count + other_count + bad_lines == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rom_loader.f
+incdir+logic
logic/rom_loader_pkg.sv
logic/dwnld_packer.sv
logic/prog_fifo.sv
logic/prog_writer.sv
logic/rom_loader_top.sv
dv/prog_checker.sv
dv/tb_rom_loader.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the rom_loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rom_loader -f rom_loader.f -o sim_rom_loader \
    && ./obj_dir/sim_rom_loader | tee sim.log \
    && grep -qx 'All tests passed!' sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: dv/rom_loader_stimulus.txt
# Columns: D level | W index byte_address byte | E expected_dipsw
# All fields hex, index 00 is ROM and FE is DIP
W FE 0000000 5A
W FE 0000002 C3
E 00C3005A
D 1
W 00 0000000 11
W 00 0000001 22
W 00 1000003 33
W 00 2ABCDE4 44
W FE 0000001 A5
E 00C3A55A
W 00 0000100 A0
W 00 0000101 A1
W 00 0000102 A2
W 00 0000103 A3
W 00 1234567 B4
W 00 1234568 B5
W 00 0FFFFFE C6
W 00 0FFFFFF C7
W 00 3000010 D8
W 00 3000011 D9
W 00 2000020 EA
W 00 2000021 EB
W 00 0555555 5C
W 00 0AAAAAA AD
W 01 0000020 77
W 00 3FFFFFF FF
D 0
W 00 0000040 99
W FE 0000007 7E
E 7EC3A55A
